// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard hw/*.svh dv/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q '^RESULT: PASS$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
+incdir+hw
+incdir+dv
hw/rv_pkg.sv
hw/rv_ctrl_if.sv
hw/rv_control.sv
hw/rv_regfile.sv
hw/rv_imm_gen.sv
hw/rv_alu.sv
hw/rv_pc_unit.sv
hw/rv_core.sv
dv/rv_core_tb.sv

// ==== dv/rv_ref_model.svh ====
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// R-type shares the I layout with {funct7, rs2} in the immediate field
function automatic word_t enc_i(input logic [6:0] op, input logic [2:0] f3, input reg_addr_t rd,
                                input reg_addr_t rs1, input logic [11:0] imm);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic word_t enc_s(input reg_addr_t rs2, input reg_addr_t rs1,
                                input logic [11:0] imm);
  return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
endfunction

function automatic word_t enc_b(input logic [2:0] f3, input reg_addr_t rs1, input reg_addr_t rs2,
                                input logic [12:0] imm);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
endfunction

function automatic word_t enc_u(input logic [6:0] op, input reg_addr_t rd, input logic [19:0] imm);
  return {imm, rd, op};
endfunction

function automatic word_t enc_j(input reg_addr_t rd, input logic [20:0] imm);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
endfunction

// integer ops as the ISA defines them
function automatic word_t alu_ref(input logic [2:0] f3, input logic alt, input word_t a,
                                  input word_t b);
  case (f3)
    3'b000: return alt ? a - b : a + b;
    3'b001: return a << b[4:0];
    3'b010: return word_t'($signed(a) < $signed(b));
    3'b011: return word_t'(a < b);
    3'b100: return a ^ b;
    3'b101: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'b110: return a | b;
    default: return a & b;
  endcase
endfunction

// executes the word at ref_pc on the shadow state
function automatic void ref_step(output logic exp_we, output logic exp_mem, output word_t exp_addr,
                                 output word_t exp_wdata, output logic exp_halt);
  word_t      insn;
  word_t      a;
  word_t      b;
  word_t      imm_i;
  word_t      res;
  word_t      nxt;
  logic [6:0] op;
  logic [2:0] f3;
  logic       wr;
  logic       taken;
  insn  = imem[ref_pc[9:2]];
  op    = insn[6:0];
  f3    = insn[14:12];
  a     = ref_regs[insn[19:15]];
  b     = ref_regs[insn[24:20]];
  imm_i = {{20{insn[31]}}, insn[31:20]};
  nxt   = ref_pc + 32'd4;
  res   = '0;
  wr    = 1'b0;
  exp_we    = 1'b0;
  exp_mem   = 1'b0;
  exp_addr  = '0;
  exp_wdata = '0;
  exp_halt  = 1'b0;
  case (op)
    7'h37: begin
      res = {insn[31:12], 12'b0};
      wr  = 1'b1;
    end
    7'h17: begin
      res = ref_pc + {insn[31:12], 12'b0};
      wr  = 1'b1;
    end
    7'h6f: begin
      res = ref_pc + 32'd4;
      wr  = 1'b1;
      nxt = ref_pc + {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
    end
    7'h67: begin
      res = ref_pc + 32'd4;
      wr  = 1'b1;
      nxt = (a + imm_i) & ~32'd1;
    end
    7'h63: begin
      case (f3)
        3'b000: taken = (a == b);
        3'b001: taken = (a != b);
        3'b100: taken = ($signed(a) < $signed(b));
        3'b101: taken = ($signed(a) >= $signed(b));
        3'b110: taken = (a < b);
        default: taken = (a >= b);
      endcase
      if (taken) begin
        nxt = ref_pc + {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
      end
    end
    7'h03: begin
      exp_mem  = 1'b1;
      exp_addr = a + imm_i;
      res      = ref_dmem[exp_addr[9:2]];
      wr       = 1'b1;
    end
    7'h23: begin
      exp_we    = 1'b1;
      exp_mem   = 1'b1;
      exp_addr  = a + {{20{insn[31]}}, insn[31:25], insn[11:7]};
      exp_wdata = b;
      ref_dmem[exp_addr[9:2]] = b;
    end
    7'h13, 7'h33: begin
      res = alu_ref(f3, insn[30] && ((op == 7'h33) || (f3 == 3'b101)), a,
                    (op == 7'h13) ? imm_i : b);
      wr  = 1'b1;
    end
    // ecall and anything unknown stop the core in place
    default: begin
      exp_halt = 1'b1;
      nxt      = ref_pc;
    end
  endcase
  if (wr && (insn[11:7] != 5'd0)) begin
    ref_regs[insn[11:7]] = res;
  end
  ref_pc = nxt;
endfunction

function automatic void emit(input word_t w);
  prog.push_back(w);
endfunction

// x31 is the store base in every program
function automatic void begin_program();
  prog.delete();
  slot = 0;
  emit(enc_i(7'h13, 3'b000, 31, 0, 12'h200));
endfunction

// lui plus addi, upper part rounded for the sign-extended low half
function automatic void load_const(input reg_addr_t rd, input word_t val);
  word_t hi;
  hi = val + 32'h800;
  emit(enc_u(7'h37, rd, hi[31:12]));
  emit(enc_i(7'h13, 3'b000, rd, rd, val[11:0]));
endfunction

function automatic void store_slot(input reg_addr_t rs2);
  emit(enc_s(rs2, 31, 12'(slot * 4)));
  slot = (slot + 1) % 64;
endfunction

`endif

// ==== dv/rv_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module rv_core_tb import rv_pkg::*; ();

  localparam int    MEM_WORDS   = 256;
  localparam int    RST_CYCLES  = 4;
  localparam int    HALT_CYCLES = 4;
  localparam word_t ECALL       = 32'h0000_0073;
  localparam word_t FENCE       = 32'h0000_000f;

  logic  clk = 1'b0;
  logic  rst = 1'b1;
  word_t pc;
  word_t insn;
  word_t dmem_addr;
  word_t dmem_rdata;
  word_t dmem_wdata;
  logic  dmem_we;
  logic  halt;

  word_t imem [MEM_WORDS];
  word_t dmem [MEM_WORDS];
  word_t prog [$];

  // shadow state of the reference
  word_t ref_regs [`RV_NUM_REGS];
  word_t ref_dmem [MEM_WORDS];
  word_t ref_pc;

  string test_name;
  int    slot;
  int    err_count;
  int    tests_run;
  int    tests_failed;
  int    halt_seen;
  int    cycles;
  int    cycle_limit;
  logic  checking = 1'b0;

  `include "rv_ref_model.svh"

  rv_core i_dut (
    .clk          (clk),
    .rst          (rst),
    .o_pc         (pc),
    .i_insn       (insn),
    .o_dmem_addr  (dmem_addr),
    .i_dmem_rdata (dmem_rdata),
    .o_dmem_wdata (dmem_wdata),
    .o_dmem_we    (dmem_we),
    .o_halt       (halt)
  );

  always #20 clk = ~clk;

  function automatic word_t fill_word(input int i);
    return (word_t'(i) * 32'h9e37_79b9) ^ 32'h5a5a_0000;
  endfunction

  // unused words decode as custom-0 and halt
  function automatic void load_imem();
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i] = (i < prog.size()) ? prog[i] : {i[24:0], 7'h0b};
    end
  endfunction

  function automatic void report_mismatch(input string what, input word_t exp, input word_t act);
    $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
    err_count++;
  endfunction

  // both memories read without a clock
  assign insn       = imem[pc[9:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        dmem[i] <= fill_word(i);
      end
    end else if (dmem_we) begin
      dmem[dmem_addr[9:2]] <= dmem_wdata;
    end
  end

  // reference steps alongside the DUT, sampled mid-cycle
  always @(negedge clk) begin
    logic  exp_we;
    logic  exp_mem;
    logic  exp_halt;
    word_t exp_addr;
    word_t exp_wdata;
    if (rst) begin
      ref_pc    = `RV_RESET_PC;
      halt_seen = 0;
      for (int i = 0; i < MEM_WORDS; i++) begin
        ref_dmem[i] = fill_word(i);
      end
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        ref_regs[i] = '0;
      end
      assert (dmem_we == 1'b0) else report_mismatch("reset o_dmem_we", 0, word_t'(dmem_we));
      assert (halt == 1'b0) else report_mismatch("reset o_halt", 0, word_t'(halt));
    end else if (checking) begin
      assert (pc == ref_pc) else report_mismatch("o_pc", ref_pc, pc);
      ref_step(exp_we, exp_mem, exp_addr, exp_wdata, exp_halt);
      assert (dmem_we == exp_we) else
        report_mismatch("o_dmem_we", word_t'(exp_we), word_t'(dmem_we));
      assert (halt == exp_halt) else report_mismatch("o_halt", word_t'(exp_halt), word_t'(halt));
      if (exp_mem) begin
        assert (dmem_addr == exp_addr) else report_mismatch("o_dmem_addr", exp_addr, dmem_addr);
      end
      if (exp_we) begin
        assert (dmem_wdata == exp_wdata) else
          report_mismatch("o_dmem_wdata", exp_wdata, dmem_wdata);
      end
      if (halt) begin
        halt_seen++;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("timeout: test %s did not halt within %0d cycles", test_name, cycle_limit);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // reset, load, then run until the core has sat in halt for a few cycles
  task automatic run_program(input string name);
    int errs_before;
    errs_before = err_count;
    test_name   = name;
    cycle_limit = cycles + 4 * (prog.size() + RST_CYCLES + HALT_CYCLES + 2);
    @(posedge clk);
    rst <= 1'b1;
    @(posedge clk);
    load_imem();
    repeat (RST_CYCLES - 1) @(posedge clk);
    rst <= 1'b0;
    checking = 1'b1;
    while (halt_seen < HALT_CYCLES) begin
      @(negedge clk);
    end
    checking = 1'b0;
    tests_run++;
    if (err_count == errs_before) begin
      $display("test %s passed, %0d instructions", name, prog.size());
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", name, err_count - errs_before);
    end
    prog.delete();
  endtask

  initial begin
    void'($urandom(1361));
    load_imem();
    // a store at the reset PC must stay quiet while rst is high
    emit(enc_s(0, 0, 12'h000));
    emit(ECALL);
    run_program("reset");
    build_alu();
    run_program("alu");
    build_upper();
    run_program("upper");
    build_branch();
    run_program("branch");
    build_mem();
    run_program("mem");
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  function automatic void build_alu();
    logic [11:0] imm;
    begin_program();
    for (int r = 0; r < 4; r++) begin
      load_const(1, $urandom());
      load_const(2, $urandom());
      for (int f = 0; f < 8; f++) begin
        emit(enc_i(7'h33, 3'(f), 3, 1, {7'h00, 5'd2}));
        store_slot(3);
        imm = 12'($urandom());
        if ((f == 1) || (f == 5)) begin
          imm = {7'h00, imm[4:0]};
        end
        emit(enc_i(7'h13, 3'(f), 4, 1, imm));
        store_slot(4);
      end
      // sub, sra and srai
      emit(enc_i(7'h33, 3'b000, 3, 1, {7'h20, 5'd2}));
      store_slot(3);
      emit(enc_i(7'h33, 3'b101, 3, 1, {7'h20, 5'd2}));
      store_slot(3);
      emit(enc_i(7'h13, 3'b101, 4, 1, {7'h20, 5'($urandom())}));
      store_slot(4);
    end
    emit(ECALL);
  endfunction

  function automatic void build_upper();
    begin_program();
    emit(enc_u(7'h37, 5, 20'($urandom())));
    store_slot(5);
    emit(enc_u(7'h17, 6, 20'($urandom())));
    store_slot(6);
    // x0 swallows every write
    emit(enc_u(7'h37, 0, 20'($urandom())));
    emit(enc_i(7'h13, 3'b000, 0, 0, 12'h5a5));
    store_slot(0);
    emit(enc_u(7'h17, 0, 20'($urandom())));
    store_slot(0);
    emit(ECALL);
  endfunction

  function automatic void build_branch();
    int        conds [6] = '{0, 1, 4, 5, 6, 7};
    reg_addr_t lhs [3] = '{5'd1, 5'd2, 5'd1};
    reg_addr_t rhs [3] = '{5'd2, 5'd1, 5'd1};
    begin_program();
    // negative against positive splits signed from unsigned
    load_const(1, $urandom() | 32'h8000_0000);
    load_const(2, $urandom() & 32'h7fff_ffff);
    for (int p = 0; p < 3; p++) begin
      for (int c = 0; c < 6; c++) begin
        emit(enc_i(7'h13, 3'b000, 7, 0, 12'd0));
        emit(enc_b(3'(conds[c]), lhs[p], rhs[p], 13'd8));
        emit(enc_i(7'h13, 3'b000, 7, 0, 12'd1));
        store_slot(7);
      end
    end
    emit(enc_j(8, 21'd8));
    emit(enc_i(7'h13, 3'b000, 9, 0, 12'd1));
    store_slot(8);
    // odd jalr offset, bit 0 is dropped
    emit(enc_u(7'h17, 10, 20'd0));
    emit(enc_i(7'h67, 3'b000, 11, 10, 12'd13));
    emit(enc_i(7'h13, 3'b000, 9, 0, 12'd2));
    store_slot(11);
    store_slot(9);
    emit(ECALL);
  endfunction

  function automatic void build_mem();
    begin_program();
    for (int i = 0; i < 4; i++) begin
      load_const(12, $urandom());
      emit(enc_s(12, 31, 12'(12'h100 + i * 8)));
      emit(enc_i(7'h03, 3'b010, 13, 31, 12'(12'h100 + i * 8)));
      store_slot(13);
    end
    emit(FENCE);
  endfunction

endmodule

`default_nettype wire

// ==== hw/rv_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_alu import rv_pkg::*; (
  input  word_t     i_a,
  input  word_t     i_b,
  rv_ctrl_if.dp     dp,
  output word_t     o_result
);

  logic [4:0] shamt;

  // only the low bits of b count for shifts
  assign shamt = i_b[4:0];

  always_comb begin
    case (dp.alu_op)
      ALU_ADD: o_result = i_a + i_b;
      ALU_SUB: o_result = i_a - i_b;
      ALU_SLL: o_result = i_a << shamt;
      ALU_SLT: begin
        o_result = ($signed(i_a) < $signed(i_b)) ? word_t'(1) : word_t'(0);
      end
      ALU_SLTU: begin
        o_result = (i_a < i_b) ? word_t'(1) : word_t'(0);
      end
      ALU_XOR: o_result = i_a ^ i_b;
      ALU_SRL: o_result = i_a >> shamt;
      // sign bit fills from the left
      ALU_SRA: o_result = word_t'($signed(i_a) >>> shamt);
      ALU_OR: o_result = i_a | i_b;
      ALU_AND: o_result = i_a & i_b;
      // lui hands its immediate straight through
      ALU_PASS_B: o_result = i_b;
      default: o_result = i_a + i_b;
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/rv_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_control import rv_pkg::*; (
  input  opcode_e    i_opcode,
  input  logic [2:0] i_funct3,
  input  logic [6:0] i_funct7,
  output logic       o_halt,
  rv_ctrl_if.ctrl    ctrl
);

  logic illegal;
  logic alt_funct7;

  // sub and sra/srai are the only legal non-zero funct7
  assign alt_funct7 = (i_funct7 == 7'b0100000) &&
                      ((i_funct3 == 3'b000) || (i_funct3 == 3'b101));

  always_comb begin
    ctrl.alu_op        = ALU_ADD;
    ctrl.imm_sel       = IMM_I;
    ctrl.alu_src_imm   = 1'b0;
    ctrl.alu_src_pc    = 1'b0;
    ctrl.reg_we        = 1'b0;
    ctrl.wb_sel        = WB_ALU;
    ctrl.pc_sel        = PC_SEQ;
    ctrl.mem_we        = 1'b0;
    ctrl.branch_funct3 = i_funct3;
    illegal            = 1'b0;

    case (i_opcode)
      OP_LUI: begin
        ctrl.reg_we      = 1'b1;
        ctrl.imm_sel     = IMM_U;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_op      = ALU_PASS_B;
      end
      OP_AUIPC: begin
        ctrl.reg_we      = 1'b1;
        ctrl.imm_sel     = IMM_U;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_src_pc  = 1'b1;
      end
      OP_JAL: begin
        ctrl.reg_we  = 1'b1;
        ctrl.imm_sel = IMM_J;
        ctrl.wb_sel  = WB_PC4;
        ctrl.pc_sel  = PC_JAL;
      end
      OP_JALR: begin
        ctrl.reg_we = 1'b1;
        ctrl.wb_sel = WB_PC4;
        ctrl.pc_sel = PC_JALR;
        illegal     = (i_funct3 != 3'b000);
      end
      OP_BRANCH: begin
        ctrl.imm_sel = IMM_B;
        ctrl.pc_sel  = PC_BRANCH;
        // 010 and 011 are not branch conditions
        illegal      = (i_funct3[2:1] == 2'b01);
      end
      OP_LOAD: begin
        ctrl.reg_we      = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.wb_sel      = WB_LOAD;
        // word only
        illegal          = (i_funct3 != 3'b010);
      end
      OP_STORE: begin
        ctrl.mem_we      = 1'b1;
        ctrl.imm_sel     = IMM_S;
        ctrl.alu_src_imm = 1'b1;
        illegal          = (i_funct3 != 3'b010);
      end
      OP_IMM, OP_OP: begin
        ctrl.reg_we      = 1'b1;
        ctrl.alu_src_imm = (i_opcode == OP_IMM);
        case (i_funct3)
          3'b000: ctrl.alu_op = (i_opcode == OP_OP && i_funct7[5]) ? ALU_SUB : ALU_ADD;
          3'b001: ctrl.alu_op = ALU_SLL;
          3'b010: ctrl.alu_op = ALU_SLT;
          3'b011: ctrl.alu_op = ALU_SLTU;
          3'b100: ctrl.alu_op = ALU_XOR;
          3'b101: ctrl.alu_op = i_funct7[5] ? ALU_SRA : ALU_SRL;
          3'b110: ctrl.alu_op = ALU_OR;
          default: ctrl.alu_op = ALU_AND;
        endcase
        // immediate ops only carry funct7 in the shift encodings
        if ((i_opcode == OP_OP) || (i_funct3 == 3'b001) || (i_funct3 == 3'b101)) begin
          if ((i_funct7 != 7'b0000000) && !alt_funct7) begin
            illegal = 1'b1;
          end
        end
      end
      // ecall and everything else in system space stops the core
      default: illegal = 1'b1;
    endcase

    if (illegal) begin
      ctrl.reg_we = 1'b0;
      ctrl.mem_we = 1'b0;
      ctrl.pc_sel = PC_SEQ;
    end
    o_halt = illegal;
  end

  // no instruction writes both register and memory
  always_comb begin
    assert (!(ctrl.reg_we && ctrl.mem_we));
  end

endmodule

`default_nettype wire

// ==== hw/rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  output word_t o_pc,
  input  word_t i_insn,
  output word_t o_dmem_addr,
  input  word_t i_dmem_rdata,
  output word_t o_dmem_wdata,
  output logic  o_dmem_we,
  output logic  o_halt
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t  rd;
  reg_addr_t  rs1;
  reg_addr_t  rs2;
  word_t      rs1_data;
  word_t      rs2_data;
  word_t      rd_data;
  word_t      imm;
  word_t      alu_a;
  word_t      alu_b;
  word_t      alu_result;
  word_t      pc_plus4;
  logic       halt;

  // R-type field split
  assign opcode = opcode_e'(i_insn[6:0]);
  assign rd     = i_insn[11:7];
  assign funct3 = i_insn[14:12];
  assign rs1    = i_insn[19:15];
  assign rs2    = i_insn[24:20];
  assign funct7 = i_insn[31:25];

  rv_ctrl_if ctrl_if ();

  rv_control u_control (
    .i_opcode (opcode),
    .i_funct3 (funct3),
    .i_funct7 (funct7),
    .o_halt   (halt),
    .ctrl     (ctrl_if.ctrl)
  );

  rv_regfile u_regfile (
    .clk        (clk),
    .rst        (rst),
    .i_we       (ctrl_if.reg_we && !rst),
    .i_rd       (rd),
    .i_rd_data  (rd_data),
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  rv_imm_gen u_imm_gen (.i_insn(i_insn), .dp(ctrl_if.dp), .o_imm(imm));

  // auipc takes the pc, everything else rs1
  assign alu_a = ctrl_if.alu_src_pc ? o_pc : rs1_data;
  assign alu_b = ctrl_if.alu_src_imm ? imm : rs2_data;

  rv_alu u_alu (.i_a(alu_a), .i_b(alu_b), .dp(ctrl_if.dp), .o_result(alu_result));

  rv_pc_unit u_pc_unit (
    .clk        (clk),
    .rst        (rst),
    .i_stall    (halt),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .i_imm      (imm),
    .dp         (ctrl_if.dp),
    .o_pc       (o_pc),
    .o_pc_plus4 (pc_plus4)
  );

  // loads and stores address with the alu sum
  assign o_dmem_addr  = alu_result;
  assign o_dmem_wdata = rs2_data;
  assign o_dmem_we    = ctrl_if.mem_we && !rst;
  assign o_halt       = halt && !rst;

  always_comb begin
    case (ctrl_if.wb_sel)
      WB_LOAD: rd_data = i_dmem_rdata;
      WB_PC4: rd_data = pc_plus4;
      default: rd_data = alu_result;
    endcase
  end

  a_store_aligned: assert property (@(posedge clk) disable iff (rst)
    o_dmem_we |-> (o_dmem_addr[1:0] == 2'b00));

endmodule

`default_nettype wire

// ==== hw/rv_ctrl_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// decoded control bundle, decoder to datapath
interface rv_ctrl_if import rv_pkg::*; ();

  alu_op_e alu_op;
  imm_sel_e imm_sel;
  logic alu_src_imm;
  logic alu_src_pc;
  logic reg_we;
  wb_sel_e wb_sel;
  pc_sel_e pc_sel;
  logic mem_we;
  logic [2:0] branch_funct3;

  modport ctrl (
    output alu_op, imm_sel, alu_src_imm, alu_src_pc, reg_we, wb_sel, pc_sel, mem_we,
    output branch_funct3
  );

  modport dp (
    input alu_op, imm_sel, alu_src_imm, alu_src_pc, reg_we, wb_sel, pc_sel, mem_we,
    input branch_funct3
  );

endinterface

`default_nettype wire

// ==== hw/rv_imm_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_imm_gen import rv_pkg::*; (
  input  word_t     i_insn,
  rv_ctrl_if.dp     dp,
  output word_t     o_imm
);

  always_comb begin
    case (dp.imm_sel)
      IMM_I: o_imm = {{20{i_insn[31]}}, i_insn[31:20]};
      IMM_S: o_imm = {{20{i_insn[31]}}, i_insn[31:25], i_insn[11:7]};
      // branch offset, halfword granular
      IMM_B: begin
        o_imm = {{19{i_insn[31]}}, i_insn[31], i_insn[7], i_insn[30:25],
                 i_insn[11:8], 1'b0};
      end
      IMM_U: o_imm = {i_insn[31:12], 12'b0};
      IMM_J: begin
        o_imm = {{11{i_insn[31]}}, i_insn[31], i_insn[19:12], i_insn[20],
                 i_insn[30:21], 1'b0};
      end
      default: o_imm = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/rv_params.svh ====
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// data, address and instruction width
`define RV_XLEN 32

// register index width and count
`define RV_REG_AW 5
`define RV_NUM_REGS 32

// fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif

// ==== hw/rv_pc_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module rv_pc_unit import rv_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  i_stall,
  input  word_t i_rs1_data,
  input  word_t i_rs2_data,
  input  word_t i_imm,
  rv_ctrl_if.dp dp,
  output word_t o_pc,
  output word_t o_pc_plus4
);

  word_t pc_q;
  word_t pc_next;
  logic  taken;

  // branch condition from funct3
  always_comb begin
    case (dp.branch_funct3)
      3'b000: taken = (i_rs1_data == i_rs2_data);
      3'b001: taken = (i_rs1_data != i_rs2_data);
      3'b100: taken = ($signed(i_rs1_data) < $signed(i_rs2_data));
      3'b101: taken = ($signed(i_rs1_data) >= $signed(i_rs2_data));
      3'b110: taken = (i_rs1_data < i_rs2_data);
      3'b111: taken = (i_rs1_data >= i_rs2_data);
      default: taken = 1'b0;
    endcase
  end

  assign o_pc_plus4 = pc_q + 32'd4;

  always_comb begin
    case (dp.pc_sel)
      PC_BRANCH: pc_next = taken ? (pc_q + i_imm) : o_pc_plus4;
      PC_JAL: pc_next = pc_q + i_imm;
      PC_JALR: pc_next = (i_rs1_data + i_imm) & ~32'd1;
      default: pc_next = o_pc_plus4;
    endcase
  end

  // halt freezes the fetch address
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= `RV_RESET_PC;
    end else if (!i_stall) begin
      pc_q <= pc_next;
    end
  end

  assign o_pc = pc_q;

  a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc_q[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== hw/rv_pkg.sv ====
`default_nettype none

`include "rv_params.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [`RV_REG_AW-1:0] reg_addr_t;

  // major opcodes, insn[6:0]
  typedef enum logic [6:0] {
    OP_LOAD   = 7'b00_000_11,
    OP_STORE  = 7'b01_000_11,
    OP_BRANCH = 7'b11_000_11,
    OP_JALR   = 7'b11_001_11,
    OP_JAL    = 7'b11_011_11,
    OP_IMM    = 7'b00_100_11,
    OP_OP     = 7'b01_100_11,
    OP_AUIPC  = 7'b00_101_11,
    OP_LUI    = 7'b01_101_11,
    OP_SYSTEM = 7'b11_100_11
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_sel_e;

  // register writeback source
  typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_PC4} wb_sel_e;

  typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JAL, PC_JALR} pc_sel_e;

endpackage

`default_nettype wire

// ==== hw/rv_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module rv_regfile import rv_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      i_we,
  input  reg_addr_t i_rd,
  input  word_t     i_rd_data,
  input  reg_addr_t i_rs1,
  input  reg_addr_t i_rs2,
  output word_t     o_rs1_data,
  output word_t     o_rs2_data
);

  word_t regs [`RV_NUM_REGS];

  // x0 is cleared by reset and never written
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_rd != '0)) begin
      regs[i_rd] <= i_rd_data;
    end
  end

  assign o_rs1_data = regs[i_rs1];
  assign o_rs2_data = regs[i_rs2];

  a_x0_zero: assert property (@(posedge clk) disable iff (rst)
    ((i_rs1 != '0) || (o_rs1_data == '0)) && ((i_rs2 != '0) || (o_rs2_data == '0)));

endmodule

`default_nettype wire
